//--- tapnw_pkg.sv
// Shared definitions for the JTAG TAP network
// Imported by the TAP controllers, master TAP, slave TAPs, top level and testbench
package tapnw_pkg;

   // ********************************************************
   // Instruction register
   // ********************************************************
   localparam int IR_WIDTH = 4;
   typedef logic [IR_WIDTH-1:0] ir_t;

   // Instruction codes
   localparam ir_t IR_IDCODE  = 4'h1;
   localparam ir_t IR_NWCFG   = 4'h2;
   localparam ir_t IR_BYPASS  = 4'hF;
   // Fixed pattern loaded in Capture-IR, shifted out LSB first
   localparam ir_t IR_CAPTURE = 4'b0001;

   // ********************************************************
   // Identification
   // ********************************************************
   typedef logic [31:0] idcode_t;
   // Master TAP IDCODE, stap k reports IDCODE_BASE + k + 1
   localparam idcode_t IDCODE_BASE = 32'h1A5C_0001;

   // ********************************************************
   // TAP controller states, 1149.1 style encoding
   // ********************************************************
   typedef enum logic [3:0] {
      TAP_EXIT2_DR  = 4'h0,
      TAP_EXIT1_DR  = 4'h1,
      TAP_SHIFT_DR  = 4'h2,
      TAP_PAUSE_DR  = 4'h3,
      TAP_SEL_IR    = 4'h4,
      TAP_UPD_DR    = 4'h5,
      TAP_CAP_DR    = 4'h6,
      TAP_SEL_DR    = 4'h7,
      TAP_EXIT2_IR  = 4'h8,
      TAP_EXIT1_IR  = 4'h9,
      TAP_SHIFT_IR  = 4'hA,
      TAP_PAUSE_IR  = 4'hB,
      TAP_RTI       = 4'hC,
      TAP_UPD_IR    = 4'hD,
      TAP_CAP_IR    = 4'hE,
      TAP_TLR       = 4'hF
   } tap_state_t;

endpackage

//--- tapnw_stap_if.sv
// Per-stap signal bundle between the master TAP, the data path and the staps
// One bit per stap in every vector, sized by NUM_STAPS from the top level
interface tapnw_stap_if
#(
   parameter int NUM_STAPS = 4
)
();

   // Serial input to each stap, steered by the data path
   logic [NUM_STAPS-1:0] stap_tdi;
   // Serial output and output enable of each stap
   logic [NUM_STAPS-1:0] stap_tdo;
   logic [NUM_STAPS-1:0] stap_tdo_en;
   // Stap enable from the network configuration register
   logic [NUM_STAPS-1:0] stap_enable;

   // Chain steering side
   modport data_path (
      output stap_tdi,
      input  stap_tdo,
      input  stap_tdo_en,
      input  stap_enable
   );

   // Slave TAP side, sliced per stap at the top level
   modport stap (
      input  stap_tdi,
      input  stap_enable,
      output stap_tdo,
      output stap_tdo_en
   );

   // Master TAP configuration side
   modport cfg (
      output stap_enable
   );

endinterface

//--- tapnw_tap_fsm.sv
// IEEE 1149.1 TAP controller
// One instance per TAP, walks the 16 states on tms at the tck rising edge
module tapnw_tap_fsm
   import tapnw_pkg::*;
(
   input  logic       tck,
   input  logic       reset,
   input  logic       tms,
   output tap_state_t state
);

   tap_state_t next_state;

   // ********************************************************
   // Next state from tms
   // ********************************************************
   always_comb
   begin
      case (state)
         // Reset and idle
         TAP_TLR:      next_state = tms ? TAP_TLR      : TAP_RTI;
         TAP_RTI:      next_state = tms ? TAP_SEL_DR   : TAP_RTI;
         // Data register column
         TAP_SEL_DR:   next_state = tms ? TAP_SEL_IR   : TAP_CAP_DR;
         TAP_CAP_DR:   next_state = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
         TAP_SHIFT_DR: next_state = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
         TAP_EXIT1_DR: next_state = tms ? TAP_UPD_DR   : TAP_PAUSE_DR;
         TAP_PAUSE_DR: next_state = tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
         TAP_EXIT2_DR: next_state = tms ? TAP_UPD_DR   : TAP_SHIFT_DR;
         TAP_UPD_DR:   next_state = tms ? TAP_SEL_DR   : TAP_RTI;
         // Instruction register column
         TAP_SEL_IR:   next_state = tms ? TAP_TLR      : TAP_CAP_IR;
         TAP_CAP_IR:   next_state = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
         TAP_SHIFT_IR: next_state = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
         TAP_EXIT1_IR: next_state = tms ? TAP_UPD_IR   : TAP_PAUSE_IR;
         TAP_PAUSE_IR: next_state = tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
         TAP_EXIT2_IR: next_state = tms ? TAP_UPD_IR   : TAP_SHIFT_IR;
         TAP_UPD_IR:   next_state = tms ? TAP_SEL_DR   : TAP_RTI;
         default:      next_state = TAP_TLR;
      endcase
   end

   // ********************************************************
   // State register
   // ********************************************************
   // Synchronous reset stands in for TRST
   always_ff @(posedge tck)
   begin
      if (reset)
      begin
         state <= TAP_TLR;
      end
      else
      begin
         state <= next_state;
      end
   end

   // Controller must stay on a defined state once out of reset
   a_state_known: assert property (
      @(posedge tck) disable iff (reset)
      !$isunknown(state)
   );

endmodule

//--- tapnw_mtap.sv
// Master TAP of the network
// Holds the network configuration register that enables, includes and steers
// each stap, plus the usual IDCODE and BYPASS data registers
module tapnw_mtap
   import tapnw_pkg::*;
#(
   parameter int NUM_STAPS = 4
)
(
   input  logic                 tck,
   input  logic                 reset,
   input  logic                 tms,
   input  logic                 tdi,
   output logic                 mtap_tdo,
   output logic                 mtap_tdo_en,
   output logic [NUM_STAPS-1:0] enable_tdo,
   output logic [NUM_STAPS-1:0] sec_sel,
   tapnw_stap_if.cfg            cfg
);

   localparam int CFG_WIDTH = 3 * NUM_STAPS;

   tap_state_t           state;
   ir_t                  ir;
   ir_t                  ir_sr;
   idcode_t              idcode_sr;
   logic                 bypass_sr;
   logic [CFG_WIDTH-1:0] cfg_sr;
   logic [CFG_WIDTH-1:0] nwcfg;
   logic                 sel_nwcfg;
   logic                 sel_idcode;
   logic                 shifting;
   logic                 tdo_mux;

   tapnw_tap_fsm u_fsm (
      .tck   (tck),
      .reset (reset),
      .tms   (tms),
      .state (state)
   );

   // DR select, unknown codes fall to bypass
   assign sel_nwcfg  = (ir == IR_NWCFG);
   assign sel_idcode = (ir == IR_IDCODE);
   assign shifting   = (state == TAP_SHIFT_IR) || (state == TAP_SHIFT_DR);

   // ********************************************************
   // Instruction register
   // ********************************************************
   always_ff @(posedge tck)
   begin
      if (state == TAP_CAP_IR)
      begin
         ir_sr <= IR_CAPTURE;
      end
      else if (state == TAP_SHIFT_IR)
      begin
         ir_sr <= {tdi, ir_sr[IR_WIDTH-1:1]};
      end
   end

   always_ff @(posedge tck)
   begin
      if (reset || (state == TAP_TLR))
      begin
         ir <= IR_IDCODE;
      end
      else if (state == TAP_UPD_IR)
      begin
         ir <= ir_sr;
      end
   end

   // ********************************************************
   // Data registers, only the selected one captures and shifts
   // ********************************************************
   always_ff @(posedge tck)
   begin
      if (state == TAP_CAP_DR)
      begin
         if (sel_nwcfg)
            cfg_sr <= nwcfg;
         else if (sel_idcode)
            idcode_sr <= IDCODE_BASE;
         else
            bypass_sr <= 1'b0;
      end
      else if (state == TAP_SHIFT_DR)
      begin
         if (sel_nwcfg)
            cfg_sr <= {tdi, cfg_sr[CFG_WIDTH-1:1]};
         else if (sel_idcode)
            idcode_sr <= {tdi, idcode_sr[31:1]};
         else
            bypass_sr <= tdi;
      end
   end

   // Configuration only clears on reset, TLR keeps the network as set
   always_ff @(posedge tck)
   begin
      if (reset)
      begin
         nwcfg <= '0;
      end
      else if ((state == TAP_UPD_DR) && sel_nwcfg)
      begin
         nwcfg <= cfg_sr;
      end
   end

   // Field split, LSB first
   assign cfg.stap_enable = nwcfg[NUM_STAPS-1:0];
   assign enable_tdo      = nwcfg[2*NUM_STAPS-1:NUM_STAPS];
   assign sec_sel         = nwcfg[CFG_WIDTH-1:2*NUM_STAPS];

   // ********************************************************
   // Serial out, retimed on the falling edge
   // ********************************************************
   always_comb
   begin
      if (state == TAP_SHIFT_IR)
         tdo_mux = ir_sr[0];
      else if (sel_nwcfg)
         tdo_mux = cfg_sr[0];
      else if (sel_idcode)
         tdo_mux = idcode_sr[0];
      else
         tdo_mux = bypass_sr;
   end

   always_ff @(negedge tck)
   begin
      if (reset)
      begin
         mtap_tdo    <= 1'b0;
         mtap_tdo_en <= 1'b0;
      end
      else
      begin
         mtap_tdo_en <= shifting;
         // Hold the last bit outside shift states
         if (shifting)
            mtap_tdo <= tdo_mux;
      end
   end

   // First Shift-IR bit on the serial out is the LSB of the capture pattern
   a_ir_capture: assert property (
      @(posedge tck) disable iff (reset)
      (($past(state) == TAP_CAP_IR) && (state == TAP_SHIFT_IR)) |-> (mtap_tdo == IR_CAPTURE[0])
   );

endmodule

//--- tapnw_stap.sv
// Slave TAP of the network
// 4-bit IR with IDCODE and BYPASS, held in Test-Logic-Reset while not enabled
module tapnw_stap
   import tapnw_pkg::*;
#(
   parameter idcode_t IDCODE = IDCODE_BASE
)
(
   input  logic tck,
   input  logic reset,
   input  logic tms,
   input  logic tdi,
   input  logic enable,
   output logic tdo,
   output logic tdo_en
);

   tap_state_t state;
   ir_t        ir;
   ir_t        ir_sr;
   idcode_t    idcode_sr;
   logic       bypass_sr;
   logic       fsm_reset;
   logic       sel_idcode;
   logic       shifting;
   logic       tdo_mux;

   // Disabled stap sits in TLR
   assign fsm_reset = reset | ~enable;

   tapnw_tap_fsm u_fsm (
      .tck   (tck),
      .reset (fsm_reset),
      .tms   (tms),
      .state (state)
   );

   assign sel_idcode = (ir == IR_IDCODE);
   assign shifting   = (state == TAP_SHIFT_IR) || (state == TAP_SHIFT_DR);

   // ********************************************************
   // Instruction register
   // ********************************************************
   always_ff @(posedge tck)
   begin
      if (state == TAP_CAP_IR)
         ir_sr <= IR_CAPTURE;
      else if (state == TAP_SHIFT_IR)
         ir_sr <= {tdi, ir_sr[IR_WIDTH-1:1]};
   end

   always_ff @(posedge tck)
   begin
      if (fsm_reset || (state == TAP_TLR))
         ir <= IR_IDCODE;
      else if (state == TAP_UPD_IR)
         ir <= ir_sr;
   end

   // ********************************************************
   // Data registers
   // ********************************************************
   // Anything but IDCODE selects the bypass bit
   always_ff @(posedge tck)
   begin
      if (state == TAP_CAP_DR)
      begin
         if (sel_idcode)
            idcode_sr <= IDCODE;
         else
            bypass_sr <= 1'b0;
      end
      else if (state == TAP_SHIFT_DR)
      begin
         if (sel_idcode)
            idcode_sr <= {tdi, idcode_sr[31:1]};
         else
            bypass_sr <= tdi;
      end
   end

   // Serial out on the falling edge
   assign tdo_mux = (state == TAP_SHIFT_IR) ? ir_sr[0] :
                    sel_idcode              ? idcode_sr[0] : bypass_sr;

   always_ff @(negedge tck)
   begin
      if (fsm_reset)
      begin
         tdo    <= 1'b0;
         tdo_en <= 1'b0;
      end
      else
      begin
         tdo_en <= enable & shifting;
         if (shifting)
            tdo <= tdo_mux;
      end
   end

endmodule

//--- tapnw_data_path.sv
// Network data path, purely combinational
// Threads the master TAP output and tdi2 through the staps onto the primary
// and secondary chains, and merges the output enables of each chain
module tapnw_data_path
#(
   parameter int NUM_STAPS        = 4,
   parameter bit STAP_TDI_ISOLATE = 1'b0
)
(
   input  logic                 itdi,
   input  logic                 itdi_en,
   input  logic                 tdi2,
   input  logic [NUM_STAPS-1:0] enable_tdo,
   input  logic [NUM_STAPS-1:0] sec_sel,
   tapnw_stap_if.data_path      taps,
   output logic                 otdo,
   output logic                 otdo_en,
   output logic                 otdo2,
   output logic                 otdo2_en
);

   // Chain taps between staps, index k is the chain value ahead of stap k
   logic [NUM_STAPS:0]   tdo_final;
   logic [NUM_STAPS:0]   tdo2_final;
   logic [NUM_STAPS-1:0] tdi_current;
   logic [NUM_STAPS-1:0] tdo_next;
   logic [NUM_STAPS-1:0] pri_tdo_en;
   logic [NUM_STAPS-1:0] sec_tdo_en;

   // Chain heads
   assign tdo_final[0]  = itdi;
   assign tdo2_final[0] = tdi2;

   // ********************************************************
   // Per stap steering
   // ********************************************************
   for (genvar k = 0; k < NUM_STAPS; k++)
   begin : g_stap
      // Pick up the chain this stap belongs to
      assign tdi_current[k] = sec_sel[k] ? tdo2_final[k] : tdo_final[k];
      // Insert the stap register or pass straight on
      assign tdo_next[k] = enable_tdo[k] ? taps.stap_tdo[k] : tdi_current[k];
      // Other chain passes this stap unchanged
      assign tdo_final[k+1]  = sec_sel[k] ? tdo_final[k] : tdo_next[k];
      assign tdo2_final[k+1] = sec_sel[k] ? tdo_next[k]  : tdo2_final[k];

      if (STAP_TDI_ISOLATE)
      begin : g_pass
         assign taps.stap_tdi[k] = tdi_current[k];
      end
      else
      begin : g_force
         // Disabled stap sees a constant high
         assign taps.stap_tdi[k] = taps.stap_enable[k] ? tdi_current[k] : 1'b1;
      end
   end

   // Chain tails
   assign otdo  = tdo_final[NUM_STAPS];
   assign otdo2 = tdo2_final[NUM_STAPS];

   // ********************************************************
   // Output enables
   // ********************************************************
   assign pri_tdo_en = taps.stap_tdo_en & ~sec_sel;
   assign sec_tdo_en = taps.stap_tdo_en & sec_sel;

   assign otdo_en  = itdi_en | (|pri_tdo_en);
   assign otdo2_en = |sec_tdo_en;

endmodule

//--- tapnw_top.sv
// Top level of the JTAG TAP network
// Master TAP, data path and NUM_STAPS slave TAPs on a shared tck, tms and reset
// Primary port is tdi/tdo, secondary port is tdi2/tdo2
module tapnw_top
   import tapnw_pkg::*;
#(
   parameter int NUM_STAPS        = 4,
   parameter bit STAP_TDI_ISOLATE = 1'b0
)
(
   input  logic tck,
   input  logic reset,
   input  logic tms,
   input  logic tdi,
   input  logic tdi2,
   output logic tdo,
   output logic tdo_en,
   output logic tdo2,
   output logic tdo2_en
);

   logic                 mtap_tdo;
   logic                 mtap_tdo_en;
   logic [NUM_STAPS-1:0] enable_tdo;
   logic [NUM_STAPS-1:0] sec_sel;

   tapnw_stap_if #(.NUM_STAPS(NUM_STAPS)) stap_bus ();

   // Master TAP heads the primary chain
   tapnw_mtap #(
      .NUM_STAPS (NUM_STAPS)
   ) u_mtap (
      .tck         (tck),
      .reset       (reset),
      .tms         (tms),
      .tdi         (tdi),
      .mtap_tdo    (mtap_tdo),
      .mtap_tdo_en (mtap_tdo_en),
      .enable_tdo  (enable_tdo),
      .sec_sel     (sec_sel),
      .cfg         (stap_bus.cfg)
   );

   tapnw_data_path #(
      .NUM_STAPS        (NUM_STAPS),
      .STAP_TDI_ISOLATE (STAP_TDI_ISOLATE)
   ) u_data_path (
      .itdi       (mtap_tdo),
      .itdi_en    (mtap_tdo_en),
      .tdi2       (tdi2),
      .enable_tdo (enable_tdo),
      .sec_sel    (sec_sel),
      .taps       (stap_bus.data_path),
      .otdo       (tdo),
      .otdo_en    (tdo_en),
      .otdo2      (tdo2),
      .otdo2_en   (tdo2_en)
   );

   // ********************************************************
   // Slave TAPs, each on its own slice of the bus
   // ********************************************************
   for (genvar k = 0; k < NUM_STAPS; k++)
   begin : g_stap
      tapnw_stap #(
         .IDCODE (IDCODE_BASE + idcode_t'(k + 1))
      ) u_stap (
         .tck    (tck),
         .reset  (reset),
         .tms    (tms),
         .tdi    (stap_bus.stap_tdi[k]),
         .enable (stap_bus.stap_enable[k]),
         .tdo    (stap_bus.stap_tdo[k]),
         .tdo_en (stap_bus.stap_tdo_en[k])
      );
   end

endmodule

//--- tb_tapnw.sv
// Testbench for the JTAG TAP network top level
// Walks the TAP controllers with tms, scans IR and DR chains and compares the
// primary and secondary outputs with a chain model built from the network config
module tb_tapnw;
   import tapnw_pkg::*;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_STAPS = 4;
   localparam int CFG_W     = 3 * NUM_STAPS;
   localparam int W         = 256;
   localparam int MAX_CYC   = 20000;

   logic tck;
   logic reset;
   logic tms;
   logic tdi;
   logic tdi2;
   logic tdo;
   logic tdo_en;
   logic tdo2;
   logic tdo2_en;

   // Snapshot of the last scan, read by the checker
   bit               sc_ir;
   int               sc_len;
   int               sc_mode;
   logic [CFG_W-1:0] sc_cfg;
   logic [W-1:0]     sc_in1;
   logic [W-1:0]     sc_in2;
   logic [W-1:0]     sc_out1;
   logic [W-1:0]     sc_out2;
   logic [W-1:0]     sc_en1;
   logic [W-1:0]     sc_en2;
   event             scan_done;

   // Current network config and DR mode (0 IDCODE, 1 BYPASS, 2 NWCFG)
   logic [CFG_W-1:0] cur_cfg;
   int               dr_mode;
   int               errors;
   int               checks;
   int               cycles;

   tapnw_top #(
      .NUM_STAPS        (NUM_STAPS),
      .STAP_TDI_ISOLATE (1'b0)
   ) DUT (
      .tck     (tck),
      .reset   (reset),
      .tms     (tms),
      .tdi     (tdi),
      .tdi2    (tdi2),
      .tdo     (tdo),
      .tdo_en  (tdo_en),
      .tdo2    (tdo2),
      .tdo2_en (tdo2_en)
   );

   initial
   begin
      tck = 1'b0;
      forever #4 tck = ~tck;
   end

   // Watchdog on the whole run
   initial
   begin
      cycles = 0;
      while (cycles < MAX_CYC)
      begin
         @(posedge tck);
         cycles++;
      end
      $display("timeout: simulation did not finish within %0d cycles", MAX_CYC);
      $display("tests failed");
      $finish;
   end

   // ***********************************************************
   // Reference chain model
   // ***********************************************************
   // Output stream of one chain: tail register first, LSB first, then the input
   function automatic logic [W-1:0] expected_stream(input bit sec, input bit is_ir,
      input int mode, input logic [CFG_W-1:0] c, input logic [W-1:0] din);
      logic [W-1:0] s;
      logic [31:0]  val;
      int           pos;
      int           rlen;
      bit           incl;
      s   = '0;
      pos = 0;
      for (int t = NUM_STAPS - 1; t >= -1; t--)
      begin
         if (t < 0)
            incl = !sec;
         else
            incl = c[t] && c[NUM_STAPS+t] && (c[2*NUM_STAPS+t] == sec);
         if (incl)
         begin
            if (is_ir)
            begin
               rlen = 4;
               val  = 32'(IR_CAPTURE);
            end
            else if (mode == 1)
            begin
               rlen = 1;
               val  = 0;
            end
            else if (mode == 2)
            begin
               rlen = CFG_W;
               val  = 32'(c);
            end
            else
            begin
               rlen = 32;
               val  = IDCODE_BASE + 32'(t + 1);
            end
            for (int b = 0; b < rlen; b++)
            begin
               if (pos < W)
                  s[pos] = val[b];
               pos++;
            end
         end
      end
      for (int b = 0; pos < W; b++)
      begin
         s[pos] = din[b];
         pos++;
      end
      return s;
   endfunction

   // Enabled staps on the secondary chain drive tdo2_en
   function automatic bit sec_active(input logic [CFG_W-1:0] c);
      return |(c[NUM_STAPS-1:0] & c[CFG_W-1:2*NUM_STAPS]);
   endfunction

   task automatic check_bit(input string name, input int idx, input logic exp_v,
      input logic act_v);
      checks++;
      assert (exp_v === act_v)
      else
      begin
         errors++;
         $display("Fail time=%0t signal=%s bit=%0d expected=%b actual=%b",
                  $time, name, idx, exp_v, act_v);
      end
   endtask

   // Comparing process, wakes on each finished scan
   initial
   begin
      logic [W-1:0] exp1;
      logic [W-1:0] exp2;
      forever
      begin
         @(scan_done);
         exp1 = expected_stream(1'b0, sc_ir, sc_mode, sc_cfg, sc_in1);
         exp2 = expected_stream(1'b1, sc_ir, sc_mode, sc_cfg, sc_in2);
         for (int i = 0; i < sc_len; i++)
         begin
            check_bit("tdo", i, exp1[i], sc_out1[i]);
            check_bit("tdo2", i, exp2[i], sc_out2[i]);
            check_bit("tdo_en", i, 1'b1, sc_en1[i]);
            check_bit("tdo2_en", i, sec_active(sc_cfg), sc_en2[i]);
         end
      end
   end

   // ***********************************************************
   // JTAG stimulus
   // ***********************************************************
   // One tck cycle, outputs sampled at the rising edge
   task automatic tick(input logic tms_v, input logic d1, input logic d2,
      output logic o1, output logic e1, output logic o2, output logic e2);
      tms  = tms_v;
      tdi  = d1;
      tdi2 = d2;
      @(posedge tck);
      o1 = tdo;
      e1 = tdo_en;
      o2 = tdo2;
      e2 = tdo2_en;
      #1;
   endtask

   // Walk cycle outside shift, both enables must be low
   task automatic walk(input logic tms_v);
      logic o1;
      logic e1;
      logic o2;
      logic e2;
      tick(tms_v, 1'b1, 1'b1, o1, e1, o2, e2);
      check_bit("tdo_en", -1, 1'b0, e1);
      check_bit("tdo2_en", -1, 1'b0, e2);
   endtask

   // Full scan from Run-Test/Idle back to Run-Test/Idle
   task automatic scan(input bit is_ir, input int len, input logic [W-1:0] d1,
      input logic [W-1:0] d2);
      walk(1'b1);
      if (is_ir)
         walk(1'b1);
      walk(1'b0);
      walk(1'b0);
      for (int i = 0; i < len; i++)
         tick(i == len - 1, d1[i], d2[i], sc_out1[i], sc_en1[i], sc_out2[i], sc_en2[i]);
      walk(1'b1);
      walk(1'b0);
      sc_ir   = is_ir;
      sc_len  = len;
      sc_mode = dr_mode;
      sc_cfg  = cur_cfg;
      sc_in1  = d1;
      sc_in2  = d2;
      -> scan_done;
   endtask

   task automatic reset_dut();
      int n;
      reset = 1'b1;
      tms   = 1'b1;
      n     = 0;
      while (n < 8)
      begin
         @(posedge tck);
         n++;
      end
      #1;
      reset   = 1'b0;
      cur_cfg = '0;
      dr_mode = 0;
      walk(1'b0);
   endtask

   // Five tms-high cycles reach Test-Logic-Reset, IRs back to IDCODE
   task automatic goto_tlr();
      logic o1;
      logic e1;
      logic o2;
      logic e2;
      for (int i = 0; i < 5; i++)
         tick(1'b1, 1'b1, 1'b1, o1, e1, o2, e2);
      walk(1'b0);
      dr_mode = 0;
   endtask

   task automatic write_cfg(input logic [CFG_W-1:0] c);
      reset_dut();
      scan(1'b1, 4, W'(IR_NWCFG), '0);
      dr_mode = 2;
      scan(1'b0, CFG_W, W'(c), '0);
      cur_cfg = c;
      // Newly enabled staps leave TLR on one idle cycle and join the master in RTI
      walk(1'b0);
   endtask

   // All ones on both chains leaves every TAP in BYPASS
   task automatic load_bypass(input int len);
      scan(1'b1, len, '1, '1);
      dr_mode = 1;
   endtask

   function automatic logic [W-1:0] random_vec();
      logic [W-1:0] v;
      for (int i = 0; i < W; i++)
         v[i] = $urandom_range(0, 1);
      return v;
   endfunction

   function automatic int count_ones(input logic [NUM_STAPS-1:0] v);
      int n;
      n = 0;
      for (int i = 0; i < NUM_STAPS; i++)
         n += v[i];
      return n;
   endfunction

   // ***********************************************************
   // Test sequence
   // ***********************************************************
   initial
   begin
      logic [NUM_STAPS-1:0] en_tdo;
      logic [NUM_STAPS-1:0] sel;
      logic o1;
      logic e1;
      logic o2;
      logic e2;
      void'($urandom(52551));
      reset   = 1'b1;
      tms     = 1'b1;
      tdi     = 1'b0;
      tdi2    = 1'b0;
      errors  = 0;
      checks  = 0;
      cur_cfg = '0;
      dr_mode = 0;
      #1;
      reset_dut();

      // Master IDCODE alone after reset
      scan(1'b0, 32, random_vec(), random_vec());

      // All staps on the primary chain, IR captures then IDCODEs
      write_cfg({{NUM_STAPS{1'b0}}, {NUM_STAPS{1'b1}}, {NUM_STAPS{1'b1}}});
      scan(1'b1, 4 * (1 + NUM_STAPS), random_vec(), random_vec());
      goto_tlr();
      scan(1'b0, 32 * (1 + NUM_STAPS) + 8, random_vec(), random_vec());

      // Bypass delay with a random set of included staps
      en_tdo = NUM_STAPS'($urandom);
      write_cfg({{NUM_STAPS{1'b0}}, en_tdo, {NUM_STAPS{1'b1}}});
      load_bypass(4 * (1 + count_ones(en_tdo)));
      scan(1'b0, 48, random_vec(), random_vec());

      // Random split between the primary and secondary chains
      sel = NUM_STAPS'($urandom);
      write_cfg({sel, {NUM_STAPS{1'b1}}, {NUM_STAPS{1'b1}}});
      scan(1'b1, 4 * (1 + NUM_STAPS), random_vec(), random_vec());
      load_bypass(4 * (1 + NUM_STAPS));
      scan(1'b0, 48, random_vec(), random_vec());

      // Reset in the middle of a DR shift
      walk(1'b1);
      walk(1'b0);
      walk(1'b0);
      for (int i = 0; i < 5; i++)
         tick(1'b0, 1'b1, 1'b0, o1, e1, o2, e2);
      reset_dut();
      scan(1'b0, 40, random_vec(), random_vec());

      for (int i = 0; i < 4; i++)
         walk(1'b0);
      $display("checks=%0d errors=%0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- flist.f
tapnw_pkg.sv
tapnw_stap_if.sv
tapnw_tap_fsm.sv
tapnw_mtap.sv
tapnw_stap.sv
tapnw_data_path.sv
tapnw_top.sv
tb_tapnw.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the TAP network testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_tapnw -f flist.f -o tb_tapnw_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_tapnw_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "tests failed" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi

echo "Simulation finished without failure"
exit 0
